// File: logic/lane_mgmt_consts.svh
`ifndef LANE_MGMT_CONSTS_SVH
`define LANE_MGMT_CONSTS_SVH

// lane geometry
`define LM_MAX_LANES   4
`define LM_LANE_BITS   32

// link packet beat width in bytes
`define LM_DLLP_BYTES  4

// output buffer rows, power of two
`define LM_FIFO_DEPTH  16

// pad bytes for partial rows
`define LM_PAD_LEGACY  8'h00
`define LM_PAD_BLOCK   8'hF7

// PIPE words per 128b/130b block
`define LM_BLOCK_WORDS 4

`endif

// File: logic/lane_mgmt_pkg.sv
`include "lane_mgmt_consts.svh"

package lane_mgmt_pkg;

  typedef logic [7:0]                   byte_t;
  typedef logic [`LM_LANE_BITS-1:0]     lane_data_t;
  typedef logic [`LM_LANE_BITS/8-1:0]   lane_k_t;
  typedef logic [`LM_MAX_LANES-1:0]     lane_mask_t;
  // legal values 1, 2 and 4
  typedef logic [2:0]                   lane_count_t;
  typedef logic [1:0]                   sync_hdr_t;

  typedef enum logic [2:0] {gen1, gen2, gen3, gen4, gen5} rate_e;

  typedef enum logic [1:0] {st_idle, st_dllp, st_os} stripe_state_e;

  typedef struct packed {
    byte_t [`LM_DLLP_BYTES-1:0] data;
    logic [`LM_DLLP_BYTES-1:0]  k;
    logic                       last;
  } dllp_beat_t;

  // one word per lane
  typedef struct packed {
    lane_data_t [`LM_MAX_LANES-1:0] data;
    lane_k_t [`LM_MAX_LANES-1:0]    k;
    logic                           last;
  } os_beat_t;

  typedef struct packed {
    lane_mask_t                     valid;
    lane_data_t [`LM_MAX_LANES-1:0] data;
    lane_k_t [`LM_MAX_LANES-1:0]    k;
    sync_hdr_t [`LM_MAX_LANES-1:0]  sync;
    lane_mask_t                     start;
    logic                           is_os;
    logic                           last;
  } lane_row_t;

endpackage

// File: logic/byte_striper.sv
`timescale 1ns/100ps
`include "lane_mgmt_consts.svh"

module byte_striper (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  lane_mgmt_pkg::dllp_beat_t  dllp_beat_i,
  input  logic                       dllp_valid_i,
  output logic                       dllp_ready_o,
  input  lane_mgmt_pkg::os_beat_t    os_beat_i,
  input  logic                       os_valid_i,
  output logic                       os_ready_o,
  input  lane_mgmt_pkg::rate_e       rate_i,
  input  lane_mgmt_pkg::lane_count_t lanes_i,
  input  logic                       fifo_full_i,
  output lane_mgmt_pkg::lane_row_t   row_o,
  output logic                       push_o,
  output lane_mgmt_pkg::rate_e       rate_o,
  output logic [5:0]                 pipe_width_o
);
  import lane_mgmt_pkg::*;

  stripe_state_e state_q, state_d;
  rate_e         rate_q;
  lane_count_t   lanes_q;
  // byte offset inside the current input beat
  logic [1:0]    boff_q, boff_d;
  // bytes already placed into the row
  logic [4:0]    fill_q, fill_d;
  lane_row_t     row_q, row_d;
  logic          push_q, push_d;

  logic [2:0]    pipe_bytes;
  logic [1:0]    slot_mask;
  logic [1:0]    lane_shift;
  logic [1:0]    lane_mask;
  logic [4:0]    row_bytes;
  lane_row_t     base_row;

  logic [4:0]    room_row;
  logic [2:0]    room_beat;
  logic [2:0]    n_place;
  logic [4:0]    pos;
  logic [1:0]    lane;
  logic [1:0]    slot;
  logic          dllp_take;
  logic          os_take;

  // empty row: every byte padded, valid set for active lanes
  function automatic lane_row_t blank_row(rate_e rate, lane_count_t lanes, logic is_os);
    lane_row_t r;
    byte_t     pad;
    pad = (rate >= gen3) ? `LM_PAD_BLOCK : `LM_PAD_LEGACY;
    r   = '0;
    for (int i = 0; i < `LM_MAX_LANES; i++) begin
      r.valid[i] = (i < lanes);
      r.data[i]  = {(`LM_LANE_BITS/8){pad}};
    end
    r.is_os = is_os;
    return r;
  endfunction

  // rate and lane count decode, from the per-packet latched values
  always_comb begin
    pipe_bytes = (rate_q >= gen3) ? 3'd4 : 3'd2;
    slot_mask  = pipe_bytes[2] ? 2'b11 : 2'b01;
    lane_shift = lanes_q[2] ? 2'd2 : (lanes_q[1] ? 2'd1 : 2'd0);
    lane_mask  = lanes_q[2] ? 2'b11 : (lanes_q[1] ? 2'b01 : 2'b00);
    row_bytes  = {2'b00, pipe_bytes} << lane_shift;
  end

  always_comb begin
    // a row on its way out is replaced by a fresh one
    base_row  = push_q ? blank_row(rate_q, lanes_q, row_q.is_os) : row_q;
    state_d   = state_q;
    boff_d    = boff_q;
    fill_d    = fill_q;
    row_d     = base_row;
    push_d    = 1'b0;
    dllp_take = 1'b0;
    os_take   = 1'b0;
    room_row  = '0;
    room_beat = '0;
    n_place   = '0;
    pos       = '0;
    lane      = '0;
    slot      = '0;

    case (state_q)
      st_idle: begin
        // ordered sets win over link packets
        if (!fifo_full_i && os_valid_i) begin
          state_d = st_os;
          row_d   = blank_row(rate_i, lanes_i, 1'b1);
          boff_d  = '0;
          fill_d  = '0;
        end else if (!fifo_full_i && dllp_valid_i) begin
          state_d = st_dllp;
          row_d   = blank_row(rate_i, lanes_i, 1'b0);
          boff_d  = '0;
          fill_d  = '0;
        end
      end

      st_dllp: begin
        if (!fifo_full_i && dllp_valid_i) begin
          room_row  = row_bytes - fill_q;
          room_beat = 3'(`LM_DLLP_BYTES) - {1'b0, boff_q};
          // a 1-lane 2-byte row takes only half a beat
          n_place   = ({2'b00, room_beat} < room_row) ? room_beat : room_row[2:0];
          for (int i = 0; i < `LM_DLLP_BYTES; i++) begin
            if (i < n_place) begin
              pos  = fill_q + 5'(i);
              lane = pos[1:0] & lane_mask;
              slot = 2'(pos >> lane_shift);
              row_d.data[lane][8*slot +: 8] = dllp_beat_i.data[boff_q + 2'(i)];
              row_d.k[lane][slot]           = dllp_beat_i.k[boff_q + 2'(i)];
            end
          end
          fill_d = fill_q + {2'b00, n_place};
          if (fill_d == row_bytes) begin
            push_d = 1'b1;
            fill_d = '0;
          end
          if ({1'b0, boff_q} + n_place == 3'(`LM_DLLP_BYTES)) begin
            dllp_take = 1'b1;
            boff_d    = '0;
            if (dllp_beat_i.last) begin
              row_d.last = 1'b1;
              push_d     = 1'b1;
              fill_d     = '0;
              state_d    = st_idle;
            end
          end else begin
            boff_d = boff_q + n_place[1:0];
          end
        end
      end

      st_os: begin
        // one byte of every lane word per cycle
        if (!fifo_full_i && os_valid_i) begin
          slot = boff_q & slot_mask;
          for (int i = 0; i < `LM_MAX_LANES; i++) begin
            if (row_d.valid[i]) begin
              row_d.data[i][8*slot +: 8] = os_beat_i.data[i][8*boff_q +: 8];
              row_d.k[i][slot]           = os_beat_i.k[i][boff_q];
            end
          end
          if (slot == slot_mask) begin
            push_d = 1'b1;
          end
          if (boff_q == 2'd3) begin
            os_take = 1'b1;
            boff_d  = '0;
            if (os_beat_i.last) begin
              row_d.last = 1'b1;
              push_d     = 1'b1;
              state_d    = st_idle;
            end
          end else begin
            boff_d = boff_q + 2'd1;
          end
        end
      end

      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_idle;
      rate_q  <= gen1;
      lanes_q <= 3'd1;
      boff_q  <= '0;
      fill_q  <= '0;
      push_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      boff_q  <= boff_d;
      fill_q  <= fill_d;
      push_q  <= push_d;
      // rate and width only change between packets
      if (state_q == st_idle && state_d != st_idle) begin
        rate_q  <= rate_i;
        lanes_q <= lanes_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    row_q <= row_d;
  end

  assign dllp_ready_o = dllp_take;
  assign os_ready_o   = os_take;
  assign row_o        = row_q;
  assign push_o       = push_q;
  assign rate_o       = rate_q;
  assign pipe_width_o = {pipe_bytes, 3'b000};

endmodule

// File: logic/block_framer.sv
`timescale 1ns/100ps
`include "lane_mgmt_consts.svh"

module block_framer (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  lane_mgmt_pkg::lane_row_t row_i,
  input  logic                     push_i,
  input  lane_mgmt_pkg::rate_e     rate_i,
  output lane_mgmt_pkg::lane_row_t row_o,
  output logic                     push_o
);
  import lane_mgmt_pkg::*;

  localparam int CntBits = $clog2(`LM_BLOCK_WORDS);
  localparam logic [CntBits-1:0] CntLast = CntBits'(`LM_BLOCK_WORDS - 1);

  // 128b/130b sync header encodings
  localparam sync_hdr_t SyncOs   = 2'b10;
  localparam sync_hdr_t SyncData = 2'b01;

  logic [CntBits-1:0] word_cnt_q;
  logic               block_start;

  assign block_start = (rate_i >= gen3) && (word_cnt_q == '0);

  always_comb begin
    row_o       = row_i;
    row_o.sync  = '0;
    row_o.start = '0;
    if (block_start) begin
      for (int i = 0; i < `LM_MAX_LANES; i++) begin
        if (row_i.valid[i]) begin
          row_o.sync[i]  = row_i.is_os ? SyncOs : SyncData;
          row_o.start[i] = 1'b1;
        end
      end
    end
  end

  assign push_o = push_i;

  // word position inside the block, restarts with every packet
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      word_cnt_q <= '0;
    end else if (push_i) begin
      if (row_i.last || word_cnt_q == CntLast) begin
        word_cnt_q <= '0;
      end else begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: logic/lane_word_fifo.sv
`timescale 1ns/100ps
`include "lane_mgmt_consts.svh"

module lane_word_fifo (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  lane_mgmt_pkg::lane_row_t row_i,
  input  logic                     push_i,
  output logic                     full_o,
  output lane_mgmt_pkg::lane_row_t row_o,
  output logic                     valid_o,
  input  logic                     ready_i
);
  import lane_mgmt_pkg::*;

  localparam int PtrBits = $clog2(`LM_FIFO_DEPTH);
  localparam logic [PtrBits:0] Depth = `LM_FIFO_DEPTH;
  // one row of headroom, the striper may still push once after full rises
  localparam logic [PtrBits:0] FullLevel = `LM_FIFO_DEPTH - 1;

  lane_row_t          mem [`LM_FIFO_DEPTH];
  logic [PtrBits-1:0] wr_ptr_q;
  logic [PtrBits-1:0] rd_ptr_q;
  logic [PtrBits:0]   count_q;
  // packets whose last row is stored
  logic [PtrBits:0]   pkt_cnt_q;
  logic               wr_en;
  logic               rd_en;
  logic               pkt_in;
  logic               pkt_out;

  assign wr_en   = push_i && (count_q != Depth);
  assign row_o   = mem[rd_ptr_q];
  assign valid_o = (pkt_cnt_q != '0);
  assign rd_en   = valid_o && ready_i;
  assign full_o  = (count_q >= FullLevel);
  assign pkt_in  = wr_en && row_i.last;
  assign pkt_out = rd_en && row_o.last;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= row_i;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pkt_cnt_q <= '0;
    end else begin
      case ({pkt_in, pkt_out})
        2'b10:   pkt_cnt_q <= pkt_cnt_q + 1'b1;
        2'b01:   pkt_cnt_q <= pkt_cnt_q - 1'b1;
        default: pkt_cnt_q <= pkt_cnt_q;
      endcase
    end
  end

endmodule

// File: logic/lane_management.sv
`timescale 1ns/100ps

module lane_management (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  lane_mgmt_pkg::dllp_beat_t  dllp_beat_i,
  input  logic                       dllp_valid_i,
  output logic                       dllp_ready_o,
  input  lane_mgmt_pkg::os_beat_t    os_beat_i,
  input  logic                       os_valid_i,
  output logic                       os_ready_o,
  input  lane_mgmt_pkg::rate_e       rate_i,
  input  lane_mgmt_pkg::lane_count_t lanes_i,
  output lane_mgmt_pkg::lane_row_t   lane_row_o,
  output logic                       row_valid_o,
  input  logic                       row_ready_i,
  output logic [5:0]                 pipe_width_o
);
  import lane_mgmt_pkg::*;

  lane_row_t strip_row;
  logic      strip_push;
  rate_e     pkt_rate;
  lane_row_t framed_row;
  logic      push;
  logic      fifo_full;

  byte_striper u_striper (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dllp_beat_i  (dllp_beat_i),
    .dllp_valid_i (dllp_valid_i),
    .dllp_ready_o (dllp_ready_o),
    .os_beat_i    (os_beat_i),
    .os_valid_i   (os_valid_i),
    .os_ready_o   (os_ready_o),
    .rate_i       (rate_i),
    .lanes_i      (lanes_i),
    .fifo_full_i  (fifo_full),
    .row_o        (strip_row),
    .push_o       (strip_push),
    .rate_o       (pkt_rate),
    .pipe_width_o (pipe_width_o)
  );

  // sync headers at block boundaries
  block_framer u_framer (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .row_i    (strip_row),
    .push_i   (strip_push),
    .rate_i   (pkt_rate),
    .row_o    (framed_row),
    .push_o   (push)
  );

  lane_word_fifo u_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .row_i    (framed_row),
    .push_i   (push),
    .full_o   (fifo_full),
    .row_o    (lane_row_o),
    .valid_o  (row_valid_o),
    .ready_i  (row_ready_i)
  );

endmodule

// File: dv/lane_mgmt_checks.svh
`ifndef LANE_MGMT_CHECKS_SVH
`define LANE_MGMT_CHECKS_SVH

// whole output row, invalid lanes already cleared by the caller
task automatic check_row(string name, lane_row_t exp, lane_row_t act);
  if (act !== exp) begin
    $display("mismatch %s: expected %h, actual %h", name, exp, act);
    mismatch_cnt++;
  end
endtask

// valid or start bits of a row
task automatic check_mask(string name, lane_mask_t exp, lane_mask_t act);
  if (act !== exp) begin
    $display("mismatch %s: expected %h, actual %h", name, exp, act);
    mismatch_cnt++;
  end
endtask

task automatic check_sync(string name, sync_hdr_t exp, sync_hdr_t act);
  if (act !== exp) begin
    $display("mismatch %s: expected %h, actual %h", name, exp, act);
    mismatch_cnt++;
  end
endtask

// PIPE width in bits, 16 or 32
task automatic check_width(string name, logic [5:0] exp, logic [5:0] act);
  if (act !== exp) begin
    $display("mismatch %s: expected %h, actual %h", name, exp, act);
    mismatch_cnt++;
  end
endtask

task automatic check_flag(string name, logic exp, logic act);
  if (act !== exp) begin
    $display("mismatch %s: expected %h, actual %h", name, exp, act);
    mismatch_cnt++;
  end
endtask

`endif

// File: dv/lane_mgmt_tb.sv
`timescale 1ns/100ps
`include "lane_mgmt_consts.svh"

module lane_mgmt_tb;
  import lane_mgmt_pkg::*;

  logic        clk_i;
  logic        arst_n_i;
  dllp_beat_t  dllp_beat_i;
  logic        dllp_valid_i;
  logic        dllp_ready_o;
  os_beat_t    os_beat_i;
  logic        os_valid_i;
  logic        os_ready_o;
  rate_e       rate_i;
  lane_count_t lanes_i;
  lane_row_t   lane_row_o;
  logic        row_valid_o;
  logic        row_ready_i;
  logic [5:0]  pipe_width_o;

  int          mismatch_cnt = 0;
  int          fail_cnt = 0;
  integer      seed = 32'h1fa2;
  string       stim_q[$];
  lane_row_t   exp_rows[$];
  int          exp_pkt[$];
  logic [5:0]  exp_width[$];
  int          n_beats = 0;
  // packets whose last beat the DUT has taken
  int          pkts_in = 0;
  bit          loaded = 0;
  bit          file_ok = 0;
  // input held off by a full FIFO at least once
  bit          stall_seen = 0;

  `include "lane_mgmt_checks.svh"

  lane_management dut_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dllp_beat_i  (dllp_beat_i),
    .dllp_valid_i (dllp_valid_i),
    .dllp_ready_o (dllp_ready_o),
    .os_beat_i    (os_beat_i),
    .os_valid_i   (os_valid_i),
    .os_ready_o   (os_ready_o),
    .rate_i       (rate_i),
    .lanes_i      (lanes_i),
    .lane_row_o   (lane_row_o),
    .row_valid_o  (row_valid_o),
    .row_ready_i  (row_ready_i),
    .pipe_width_o (pipe_width_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic load_testdata();
    int fd;
    int pkt;
    string line;
    int unsigned rv, lv, ov;
    logic [3:0] v, st;
    logic [31:0] d3, d2, d1, d0;
    logic [15:0] kk;
    logic [7:0] sy;
    logic os, lst;
    lane_row_t r;
    pkt = -1;
    fd = $fopen("dv/lane_mgmt_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        if (line.getc(0) == "P") begin
          void'($sscanf(line, "P %d %d %d", rv, lv, ov));
          pkt++;
          exp_width.push_back((rv >= 2) ? 6'd32 : 6'd16);
          stim_q.push_back(line);
        end else if (line.getc(0) == "R") begin
          void'($sscanf(line, "R %h %h %h %h %h %h %h %h %h %h",
                        v, d3, d2, d1, d0, kk, sy, st, os, lst));
          r = '0;
          r.valid = v;
          r.data = {d3, d2, d1, d0};
          r.k = kk;
          r.sync = sy;
          r.start = st;
          r.is_os = os;
          r.last = lst;
          exp_rows.push_back(r);
          exp_pkt.push_back(pkt);
        end else begin
          n_beats++;
          stim_q.push_back(line);
        end
      end
      $fclose(fd);
      file_ok = 1;
    end
  endtask

  // valid held from a falling edge until the DUT answers with ready
  task automatic wait_transfer(input bit is_os);
    bit got;
    int waited;
    got = 0;
    waited = 0;
    while (!got) begin
      #1;
      got = is_os ? os_ready_o : dllp_ready_o;
      if (!got) begin
        waited++;
      end
      // a packet start costs one cycle, a longer wait means the FIFO is full
      if (waited > 3) begin
        stall_seen = 1;
      end
      @(negedge clk_i);
    end
  endtask

  task automatic drive_stimulus();
    string line;
    int pkt;
    int unsigned rv, lv, ov;
    logic [31:0] w3, w2, w1, w0;
    logic [15:0] kk;
    logic [3:0] k4;
    logic lst;
    pkt = -1;
    foreach (stim_q[i]) begin
      line = stim_q[i];
      if (line.getc(0) == "P") begin
        void'($sscanf(line, "P %d %d %d", rv, lv, ov));
        rate_i = rate_e'(rv);
        lanes_i = lane_count_t'(lv);
        pkt++;
      end else begin
        if (line.getc(0) == "D") begin
          void'($sscanf(line, "D %h %h %h", w0, k4, lst));
          dllp_beat_i = '{data: w0, k: k4, last: lst};
          dllp_valid_i = 1'b1;
          wait_transfer(1'b0);
          dllp_valid_i = 1'b0;
        end else begin
          void'($sscanf(line, "O %h %h %h %h %h %h", w3, w2, w1, w0, kk, lst));
          os_beat_i = '{data: {w3, w2, w1, w0}, k: kk, last: lst};
          os_valid_i = 1'b1;
          wait_transfer(1'b1);
          os_valid_i = 1'b0;
        end
        check_width($sformatf("pipe_width_o packet %0d", pkt), exp_width[pkt], pipe_width_o);
        if (lst) begin
          pkts_in++;
        end
      end
    end
    if (!stall_seen) begin
      $display("input never stalled although the FIFO was never read");
      fail_cnt++;
      stall_seen = 1;
    end
  endtask

  task automatic monitor_rows();
    lane_row_t act, exp;
    int idx;
    int rnd;
    idx = 0;
    while (idx < exp_rows.size()) begin
      @(negedge clk_i);
      rnd = $random(seed);
      // no reads until the input stalls on a full FIFO, then one cycle in four
      row_ready_i = stall_seen && (rnd[1:0] == 2'b00);
      #1;
      if (row_valid_o && row_ready_i) begin
        act = lane_row_o;
        exp = exp_rows[idx];
        if (exp_pkt[idx] >= pkts_in) begin
          $display("row %0d left the FIFO before its packet was fully accepted", idx);
          fail_cnt++;
        end
        check_mask($sformatf("row %0d valid", idx), exp.valid, act.valid);
        check_mask($sformatf("row %0d start", idx), exp.start, act.start);
        for (int i = 0; i < `LM_MAX_LANES; i++) begin
          check_sync($sformatf("row %0d sync lane %0d", idx, i), exp.sync[i], act.sync[i]);
          // unused lanes carry no data
          if (!exp.valid[i]) begin
            act.data[i] = '0;
            act.k[i] = '0;
          end
        end
        check_row($sformatf("row %0d lane_row_o", idx), exp, act);
        idx++;
      end
    end
    @(negedge clk_i);
    row_ready_i = 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    dllp_beat_i = '0;
    dllp_valid_i = 1'b0;
    os_beat_i = '0;
    os_valid_i = 1'b0;
    rate_i = gen1;
    lanes_i = 3'd1;
    row_ready_i = 1'b0;
    load_testdata();
    loaded = 1;
    if (!file_ok) begin
      fail_cnt++;
    end else begin
      repeat (10) begin
        @(negedge clk_i);
        #1;
        check_flag("row_valid_o in reset", 1'b0, row_valid_o);
        check_flag("dllp_ready_o in reset", 1'b0, dllp_ready_o);
        check_flag("os_ready_o in reset", 1'b0, os_ready_o);
      end
      arst_n_i = 1'b1;
      @(negedge clk_i);
      #1;
      check_flag("row_valid_o after reset", 1'b0, row_valid_o);
      check_flag("dllp_ready_o after reset", 1'b0, dllp_ready_o);
      check_flag("os_ready_o after reset", 1'b0, os_ready_o);
      @(negedge clk_i);
      fork
        drive_stimulus();
        monitor_rows();
      join
      repeat (8) @(negedge clk_i);
      #1;
      check_flag("row_valid_o after last row", 1'b0, row_valid_o);
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // limit from test length, 8 cycles per beat and per row
  initial begin
    wait (loaded);
    #((n_beats + exp_rows.size()) * 8 * 40 + 10 * 40);
    $display("timeout: rows still missing when the time limit ran out");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: dv/lane_mgmt_testdata.txt
# P rate(0=gen1) lanes is_os | D data k last | O data3 data2 data1 data0 k last
# R valid data3 data2 data1 data0 k sync start is_os last (hex, unused lanes 0)
P 0 4 0
D 44332211 1 0
D 88776655 0 0
D 0000aa99 0 1
R f 00008844 00007733 00006622 00005511 0001 00 0 0 0
R f 00000000 00000000 000000aa 00000099 0000 00 0 0 1
P 2 1 0
D 03020100 1 0
D 07060504 0 0
D 0b0a0908 0 0
D 0f0e0d0c 0 0
D 13121110 0 0
D 17161514 0 1
R 1 00000000 00000000 00000000 03020100 0001 01 1 0 0
R 1 00000000 00000000 00000000 07060504 0000 00 0 0 0
R 1 00000000 00000000 00000000 0b0a0908 0000 00 0 0 0
R 1 00000000 00000000 00000000 0f0e0d0c 0000 00 0 0 0
R 1 00000000 00000000 00000000 13121110 0000 01 1 0 0
R 1 00000000 00000000 00000000 17161514 0000 00 0 0 1
P 2 2 1
O 12345678 12345678 4a4a4abc 4a4a4abc 0011 0
O 12345678 12345678 4a4a4a4a 4a4a4a4a 0000 1
R 3 00000000 00000000 4a4a4abc 4a4a4abc 0011 0a 3 1 0
R 3 00000000 00000000 4a4a4a4a 4a4a4a4a 0000 00 0 1 1
P 1 2 0
D 43424140 0 0
D 47464544 0 0
D 4b4a4948 0 0
D 4f4e4d4c 0 0
D 53525150 0 0
D 57565554 0 0
D 5b5a5958 0 0
D 5f5e5d5c 0 1
R 3 00000000 00000000 00004341 00004240 0000 00 0 0 0
R 3 00000000 00000000 00004745 00004644 0000 00 0 0 0
R 3 00000000 00000000 00004b49 00004a48 0000 00 0 0 0
R 3 00000000 00000000 00004f4d 00004e4c 0000 00 0 0 0
R 3 00000000 00000000 00005351 00005250 0000 00 0 0 0
R 3 00000000 00000000 00005755 00005654 0000 00 0 0 0
R 3 00000000 00000000 00005b59 00005a58 0000 00 0 0 0
R 3 00000000 00000000 00005f5d 00005e5c 0000 00 0 0 1

// File: files.f
+incdir+logic
+incdir+dv
logic/lane_mgmt_pkg.sv
logic/byte_striper.sv
logic/block_framer.sv
logic/lane_word_fifo.sv
logic/lane_management.sv
dv/lane_mgmt_tb.sv
